/* common/bike_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bicycle data types
// Telemetry fields, rider settings and the command handler states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package bike_pkg;

	// Beats per minute
	typedef logic [7:0] heart_rate_t;
	// Resolved angle, the top two bits hold the sign
	typedef logic [9:0] angle_t;
	typedef logic [7:0] speed_t;
	// Wheel size in the units the phone app uses
	typedef logic [7:0] wheel_size_t;

	// Sensor values offered to the phone
	typedef struct packed {
		heart_rate_t heart_rate;
		angle_t      angle;
		speed_t      speed;
	} telemetry_t;

	// Values the rider sets from the phone
	typedef struct packed {
		heart_rate_t heart_cap;
		wheel_size_t wheel_size;
	} settings_t;

	// The await states expect the value byte of a two-step setting
	typedef enum logic [1:0] {
		IDLE,
		AWAIT_HEART,
		AWAIT_WHEEL
	} cmd_state_t;

endpackage

`default_nettype wire

/* common/link_defs.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phone link definitions
// Serial bit timing, rider setting defaults and the command and
// response codes of the phone protocol
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// Clock cycles per serial bit, at least 8 for the receiver's start-bit timing
`define LINK_CLKS_PER_BIT 8

// Rider settings loaded at reset
`define LINK_HEART_CAP_DEFAULT 8'd200
`define LINK_WHEEL_SIZE_DEFAULT 8'd26

// Commands sent by the phone
`define LINK_CMD_HR 8'd1
`define LINK_CMD_ANGLE_SIGN 8'd2
`define LINK_CMD_ANGLE_VALUE 8'd3
`define LINK_CMD_SPEED 8'd4
`define LINK_CMD_INIT_HEART 8'd5
`define LINK_CMD_INIT_WHEEL 8'd6

// Answers to setting steps and to bad or unknown bytes
`define LINK_ACK 8'd1
`define LINK_NAK 8'd0

`endif

/* common/uart_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial link types
// The data byte and the received word with its framing flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package uart_pkg;

	// One byte as carried on the serial line
	typedef logic [7:0] byte_t;

	// A received byte, flagged when its stop bit was sampled low
	typedef struct packed {
		byte_t data;
		logic  framing_error;
	} rx_word_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+common
common/uart_pkg.sv
common/bike_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/phone_cmd_handler.sv
rtl/bike_link_top.sv
tb/bike_link_tb.sv

/* rtl/bike_link_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bicycle phone link
// Serial receiver, command handler and serial transmitter in a chain
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module bike_link_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rx_serial,
	output logic                 tx_serial,
	input  bike_pkg::telemetry_t telemetry,
	output bike_pkg::settings_t  settings
);

	logic rx_valid;
	uart_pkg::rx_word_t rx_word;
	logic tx_valid;
	logic tx_ready;
	uart_pkg::byte_t tx_byte;

	// Received bytes come as a bare pulse since the line cannot be stalled
	uart_rx u_rx (
		.clk       (clk),
		.reset     (reset),
		.rx_serial (rx_serial),
		.rx_valid  (rx_valid),
		.rx_word   (rx_word)
	);

	phone_cmd_handler u_handler (
		.clk       (clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.rx_word   (rx_word),
		.telemetry (telemetry),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_ready  (tx_ready),
		.settings  (settings)
	);

	// Answers leave through a valid/ready handshake
	uart_tx u_tx (
		.clk       (clk),
		.reset     (reset),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_ready  (tx_ready),
		.tx_serial (tx_serial)
	);

endmodule

`default_nettype wire

/* rtl/phone_cmd_handler.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Phone command handler
// Decodes each command byte, picks the one-byte answer and keeps the
// heart-rate cap and wheel size set from the phone
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "link_defs.svh"

module phone_cmd_handler (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rx_valid,
	input  uart_pkg::rx_word_t   rx_word,
	input  bike_pkg::telemetry_t telemetry,
	output logic                 tx_valid,
	output uart_pkg::byte_t      tx_byte,
	input  logic                 tx_ready,
	output bike_pkg::settings_t  settings
);

	bike_pkg::cmd_state_t state;
	bike_pkg::cmd_state_t state_next;
	bike_pkg::settings_t settings_q;
	bike_pkg::settings_t settings_next;
	uart_pkg::byte_t response;
	logic accept;

	// A byte that arrives while the last answer still waits is dropped
	assign accept = rx_valid & ~tx_valid;

	// Every path returns to IDLE unless an init command starts a setting
	always_comb
	begin
		state_next = bike_pkg::IDLE;
		settings_next = settings_q;
		response = `LINK_NAK;
		if (!rx_word.framing_error)
		begin
			case (state)
				bike_pkg::AWAIT_HEART:
				begin
					settings_next.heart_cap = rx_word.data;
					response = `LINK_ACK;
				end
				bike_pkg::AWAIT_WHEEL:
				begin
					settings_next.wheel_size = rx_word.data;
					response = `LINK_ACK;
				end
				default:
				begin
					case (rx_word.data)
						`LINK_CMD_HR:
							response = telemetry.heart_rate;
						// The phone rebuilds the angle from the sign and value answers
						`LINK_CMD_ANGLE_SIGN:
							response = {6'b0, telemetry.angle[9:8]};
						`LINK_CMD_ANGLE_VALUE:
							response = telemetry.angle[7:0];
						`LINK_CMD_SPEED:
							response = telemetry.speed;
						`LINK_CMD_INIT_HEART:
						begin
							state_next = bike_pkg::AWAIT_HEART;
							response = `LINK_ACK;
						end
						`LINK_CMD_INIT_WHEEL:
						begin
							state_next = bike_pkg::AWAIT_WHEEL;
							response = `LINK_ACK;
						end
						default:
							response = `LINK_NAK;
					endcase
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= bike_pkg::IDLE;
			settings_q.heart_cap <= `LINK_HEART_CAP_DEFAULT;
			settings_q.wheel_size <= `LINK_WHEEL_SIZE_DEFAULT;
			tx_valid <= 1'b0;
		end
		else if (accept)
		begin
			state <= state_next;
			settings_q <= settings_next;
			tx_valid <= 1'b1;
		end
		else if (tx_ready)
			tx_valid <= 1'b0;
	end

	// The answer holds until the transmitter takes it
	always_ff @(posedge clk)
	begin
		if (accept)
			tx_byte <= response;
	end

	assign settings = settings_q;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Builds the phone link testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
	--top-module bike_link_tb -o bike_link_sim \
	&& ./obj_dir/bike_link_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* tb/bike_link_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bicycle phone link testbench
// Sends serial command frames to the link, decodes the answer frames
// and checks them, together with the rider settings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "link_defs.svh"

module bike_link_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLKS_PER_BIT = `LINK_CLKS_PER_BIT;
	// A response frame starts about ten bits after the command frame starts
	localparam int RESPONSE_WAIT = 16 * CLKS_PER_BIT;
	// About 100 exchanges, each a command frame followed by an answer frame
	localparam int EXCHANGE_COUNT = 100;
	localparam int EXCHANGE_CYCLES = 2 * 10 * CLKS_PER_BIT;
	localparam int TIMEOUT_CYCLES = EXCHANGE_COUNT * EXCHANGE_CYCLES * 5 / 2;

	logic clk;
	logic reset;
	logic rx_serial;
	logic tx_serial;
	bike_pkg::telemetry_t telemetry;
	bike_pkg::settings_t settings;

	// What the settings should hold after each exchange
	bike_pkg::settings_t exp_settings;
	uart_pkg::byte_t resp_byte;
	logic resp_ok;
	logic [31:0] rng_state = 32'd29195;
	int cycle_count = 0;
	int value_errors = 0;
	int protocol_errors = 0;

	bike_link_top uut (
		.clk       (clk),
		.reset     (reset),
		.rx_serial (rx_serial),
		.tx_serial (tx_serial),
		.telemetry (telemetry),
		.settings  (settings)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Ends a run that hangs somewhere in the tests
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run was stopped after %0d clock cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_byte(input string name, input uart_pkg::byte_t got,
		input uart_pkg::byte_t expected);
		if (got !== expected)
		begin
			$display("Error %s: got %h, expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	task automatic check_settings(input string name, input bike_pkg::settings_t got,
		input bike_pkg::settings_t expected);
		if (got !== expected)
		begin
			$display("Error %s: got %h, expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	// Holds one bit on the receive line for a full bit period
	task automatic drive_bit(input logic b);
		@(posedge clk);
		rx_serial <= b;
		repeat (CLKS_PER_BIT - 1) @(posedge clk);
	endtask

	// A low stop bit makes the frame a framing error at the receiver
	task automatic send_byte(input uart_pkg::byte_t data, input logic bad_stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(~bad_stop);
		if (bad_stop)
		begin
			@(posedge clk);
			rx_serial <= 1'b1;
		end
	endtask

	// Samples the answer frame in the middle of each bit
	task automatic recv_byte();
		int waited;
		int i;
		waited = 0;
		resp_ok = 1'b1;
		resp_byte = '0;
		@(negedge clk);
		while (tx_serial !== 1'b0 && waited < RESPONSE_WAIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (tx_serial !== 1'b0)
		begin
			$display("No answer frame started on tx_serial after a command");
			protocol_errors++;
			resp_ok = 1'b0;
		end
		else
		begin
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			if (tx_serial !== 1'b0)
			begin
				$display("The start bit on tx_serial was shorter than half a bit");
				protocol_errors++;
			end
			for (i = 0; i < 8; i++)
			begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				resp_byte[i] = tx_serial;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (tx_serial !== 1'b1)
			begin
				$display("The stop bit on tx_serial was low");
				protocol_errors++;
			end
		end
	endtask

	// The answer can start before the command's stop bit ends, so both run at once
	task automatic exchange(input uart_pkg::byte_t cmd, input logic bad_stop,
		input uart_pkg::byte_t expected, input string name);
		fork
			send_byte(cmd, bad_stop);
			recv_byte();
		join
		if (resp_ok)
			check_byte(name, resp_byte, expected);
	endtask

	task automatic set_telemetry(input bike_pkg::heart_rate_t hr, input bike_pkg::angle_t angle,
		input bike_pkg::speed_t speed);
		bike_pkg::telemetry_t t;
		t.heart_rate = hr;
		t.angle = angle;
		t.speed = speed;
		@(posedge clk);
		telemetry <= t;
	endtask

	// All four queries, with answers worked out from the telemetry fields
	task automatic query_all(input bike_pkg::heart_rate_t hr, input bike_pkg::angle_t angle,
		input bike_pkg::speed_t speed);
		set_telemetry(hr, angle, speed);
		exchange(`LINK_CMD_HR, 1'b0, hr, "heart rate answer");
		exchange(`LINK_CMD_ANGLE_SIGN, 1'b0, uart_pkg::byte_t'(angle >> 8), "angle sign answer");
		exchange(`LINK_CMD_ANGLE_VALUE, 1'b0, angle[7:0], "angle value answer");
		exchange(`LINK_CMD_SPEED, 1'b0, speed, "speed answer");
	endtask

	task automatic reset_defaults();
		int i;
		exp_settings.heart_cap = `LINK_HEART_CAP_DEFAULT;
		exp_settings.wheel_size = `LINK_WHEEL_SIZE_DEFAULT;
		@(negedge clk);
		check_settings("settings", settings, exp_settings);
		// Nothing was sent, so the answer line must stay idle
		for (i = 0; i < 4 * CLKS_PER_BIT; i++)
		begin
			@(negedge clk);
			if (tx_serial !== 1'b1)
			begin
				$display("tx_serial went low after reset with no command sent");
				protocol_errors++;
				break;
			end
		end
	endtask

	task automatic fixed_queries();
		// Sign bits 10 and then 11
		query_all(8'd142, 10'h2C5, 8'd37);
		query_all(8'd96, 10'h3A1, 8'd12);
		check_settings("settings", settings, exp_settings);
	endtask

	task automatic heart_cap_setting();
		exchange(`LINK_CMD_INIT_HEART, 1'b0, `LINK_ACK, "init heart answer");
		exchange(8'd172, 1'b0, `LINK_ACK, "heart cap value answer");
		exp_settings.heart_cap = 8'd172;
		check_settings("settings", settings, exp_settings);
	endtask

	task automatic wheel_size_setting();
		set_telemetry(8'd118, 10'h0F3, 8'd51);
		exchange(`LINK_CMD_INIT_WHEEL, 1'b0, `LINK_ACK, "init wheel answer");
		exchange(8'd29, 1'b0, `LINK_ACK, "wheel size value answer");
		exp_settings.wheel_size = 8'd29;
		check_settings("settings", settings, exp_settings);
		// Back in IDLE, so a query code is a query again and not a value
		exchange(`LINK_CMD_HR, 1'b0, 8'd118, "heart rate answer after setting");
		check_settings("settings", settings, exp_settings);
	endtask

	task automatic bad_input_recovery();
		set_telemetry(8'd130, 10'h155, 8'd44);
		exchange(8'h7E, 1'b0, `LINK_NAK, "unknown command answer");
		exchange(`LINK_CMD_INIT_HEART, 1'b0, `LINK_ACK, "init heart answer");
		exchange(8'd90, 1'b1, `LINK_NAK, "framing error answer");
		check_settings("settings", settings, exp_settings);
		// The speed code must come back as a speed and not as a stored value
		exchange(`LINK_CMD_SPEED, 1'b0, 8'd44, "speed answer after framing error");
		check_settings("settings", settings, exp_settings);
	endtask

	task automatic random_telemetry_rounds();
		int round;
		for (round = 0; round < 20; round++)
		begin
			rng_state = xorshift32(rng_state);
			query_all(rng_state[7:0], rng_state[17:8], rng_state[25:18]);
		end
		check_settings("settings", settings, exp_settings);
	endtask

	initial
	begin
		reset <= 1'b1;
		rx_serial <= 1'b1;
		telemetry <= '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		reset_defaults();
		fixed_queries();
		heart_cap_setting();
		wheel_size_setting();
		bad_input_recovery();
		random_telemetry_rounds();

		$display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver
// Oversamples the phone's serial line and hands over each byte with a
// framing-error flag as a one-cycle valid pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "link_defs.svh"

module uart_rx (
	input  logic               clk,
	input  logic               reset,
	input  logic               rx_serial,
	output logic               rx_valid,
	output uart_pkg::rx_word_t rx_word
);

	localparam int CLKS_PER_BIT = `LINK_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	// Two sync flops, the edge compare and the load cycle already use four
	// cycles of the first half bit
	localparam int START_WAIT = CLKS_PER_BIT / 2 - 4;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic bit_tick;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	uart_pkg::byte_t shift_q;

	// The line idles high, so the flops come out of reset high and no false
	// start edge is seen
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_serial;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// A frame starts on a high to low change of the synchronized line
	assign start_edge = rx_prev & ~rx_sync;

	// The down counter hits zero at each sample point
	assign bit_tick = (clk_cnt == '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_valid <= 1'b0;
			if (state != RX_IDLE)
			begin
				if (bit_tick)
					clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
				else
					clk_cnt <= clk_cnt - 1'b1;
			end
			case (state)
				RX_IDLE:
				begin
					if (start_edge)
					begin
						state <= RX_START;
						clk_cnt <= CNT_W'(START_WAIT);
					end
				end
				RX_START:
				begin
					// A start bit that is high again at its sample point was a glitch
					if (bit_tick)
					begin
						state <= rx_sync ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
					end
				end
				RX_DATA:
				begin
					if (bit_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				default:
				begin
					// Stop bit sampled, the byte goes out whatever its level
					if (bit_tick)
					begin
						state <= RX_IDLE;
						rx_valid <= 1'b1;
					end
				end
			endcase
		end
	end

	// Data arrives least significant bit first and shifts in from the top
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && bit_tick)
			shift_q <= {rx_sync, shift_q[7:1]};
		if (state == RX_STOP && bit_tick)
		begin
			rx_word.data <= shift_q;
			rx_word.framing_error <= ~rx_sync;
		end
	end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter
// Sends one accepted byte as start bit, eight data bits and stop bit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "link_defs.svh"

module uart_tx (
	input  logic            clk,
	input  logic            reset,
	input  logic            tx_valid,
	input  uart_pkg::byte_t tx_byte,
	output logic            tx_ready,
	output logic            tx_serial
);

	localparam int CLKS_PER_BIT = `LINK_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

	tx_state_t state;
	logic [CNT_W-1:0] clk_cnt;
	// Number of the bit on the line, 0 is the start bit and 9 the stop bit
	logic [3:0] bit_cnt;
	uart_pkg::byte_t shift_q;
	logic bit_done;

	// Only an idle transmitter takes a byte
	assign tx_ready = (state == TX_IDLE);

	assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx_serial <= 1'b1;
		end
		else if (state == TX_IDLE)
		begin
			if (tx_valid)
			begin
				// Start bit goes on the line in the next cycle
				state <= TX_SEND;
				clk_cnt <= '0;
				bit_cnt <= '0;
				tx_serial <= 1'b0;
			end
		end
		else if (bit_done)
		begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9)
				state <= TX_IDLE;
			else
			begin
				bit_cnt <= bit_cnt + 1'b1;
				tx_serial <= shift_q[0];
			end
		end
		else
			clk_cnt <= clk_cnt + 1'b1;
	end

	// Ones shift in behind the data, so the ninth bit out is the stop bit
	always_ff @(posedge clk)
	begin
		if (tx_valid && tx_ready)
			shift_q <= tx_byte;
		else if (state == TX_SEND && bit_done)
			shift_q <= {1'b1, shift_q[7:1]};
	end

endmodule

`default_nettype wire
